// File: hdl/prng_pkg.sv
package prng_pkg;

	// Key and hash width
	localparam int KEY_BITS = 256;
	// One output word and one stream word into the HMAC
	localparam int WORD_BITS = 32;
	localparam int COUNT_BITS = 128;
	// Counter goes into the hash as four words, lowest first
	localparam int COUNT_WORDS = 4;
	// Words served from one hash
	localparam int BLOCK_WORDS = 8;
	// Rekey once every 1024 blocks
	localparam int REKEY_LOG2 = 10;

	// SHA-256 round constants
	localparam logic [31:0] SHA_K [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Initial hash value, word H0 in the top bits
	localparam logic [KEY_BITS-1:0] SHA_H0 = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// Block generator states
	typedef enum logic [3:0] {
		IDLE           = 4'h0,
		INIT           = 4'h1,
		INPUT          = 4'h2,
		FINALIZE       = 4'h3,
		WAIT           = 4'h4,
		REKEY_INIT     = 4'h5,
		REKEY_INPUT    = 4'h6,
		REKEY_FINALIZE = 4'h7,
		REKEY_WAIT     = 4'h8
	} gen_state_t;

endpackage

// File: hdl/sha256_compress.sv
`timescale 1ns/10ps

module sha256_compress import prng_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic [KEY_BITS-1:0]   chain_in,
	input  logic [2*KEY_BITS-1:0] block_in,
	output logic                  done,
	output logic [KEY_BITS-1:0]   digest
);

	function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic logic [31:0] big_sigma0(input logic [31:0] x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic logic [31:0] big_sigma1(input logic [31:0] x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic logic [31:0] small_sigma0(input logic [31:0] x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic logic [31:0] small_sigma1(input logic [31:0] x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	logic                 busy;
	// Bit 6 set means all 64 rounds are done
	logic [6:0]           round;
	logic [KEY_BITS-1:0]  chain;
	// Working variables a..h
	logic [WORD_BITS-1:0] v [8];
	// Message schedule window, w[0] is the word of this round
	logic [WORD_BITS-1:0] w [16];
	logic [WORD_BITS-1:0] t1;
	logic [WORD_BITS-1:0] t2;
	logic [WORD_BITS-1:0] w_next;

	// One round worth of logic
	always_comb begin
		t1 = v[7] + big_sigma1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6]))
			+ SHA_K[round[5:0]] + w[0];
		t2 = big_sigma0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		// Schedule word sixteen ahead of the current one
		w_next = small_sigma1(w[14]) + w[9] + small_sigma0(w[1]) + w[0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			round <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= 1'b1;
				round <= '0;
			end else if (busy) begin
				// Extra cycle after round 63 for the final add
				if (round[6]) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					round <= round + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			chain <= chain_in;
			// Word 0 of the block sits in the top bits
			for (int i = 0; i < 16; i++)
				w[i] <= block_in[2*KEY_BITS-1-WORD_BITS*i -: WORD_BITS];
			for (int i = 0; i < 8; i++)
				v[i] <= chain_in[KEY_BITS-1-WORD_BITS*i -: WORD_BITS];
		end else if (busy && !round[6]) begin
			v[0] <= t1 + t2;
			v[1] <= v[0];
			v[2] <= v[1];
			v[3] <= v[2];
			v[4] <= v[3] + t1;
			v[5] <= v[4];
			v[6] <= v[5];
			v[7] <= v[6];
			// Slide the window along
			for (int i = 0; i < 15; i++)
				w[i] <= w[i+1];
			w[15] <= w_next;
		end else if (busy) begin
			// Feed forward of the chaining value
			for (int i = 0; i < 8; i++)
				digest[KEY_BITS-1-WORD_BITS*i -: WORD_BITS] <=
					chain[KEY_BITS-1-WORD_BITS*i -: WORD_BITS] + v[i];
		end
	end

	// Caller must wait for done before the next block
	assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

// File: hdl/hmac_sha256.sv
`timescale 1ns/10ps

module hmac_sha256 import prng_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 key_update,
	input  logic [KEY_BITS-1:0]  key,
	input  logic                 start,
	input  logic                 update,
	input  logic [WORD_BITS-1:0] data_in,
	input  logic                 finalize,
	output logic                 ready,
	output logic                 hash_valid,
	output logic [KEY_BITS-1:0]  hash
);

	// Which compression is in flight
	typedef enum logic [2:0] {
		H_IDLE, H_IKEY, H_COLLECT, H_MSG, H_OKEY, H_OUTER
	} hmac_phase_t;

	hmac_phase_t           phase;
	logic [KEY_BITS-1:0]   key_reg;
	logic [KEY_BITS-1:0]   inner;
	logic [WORD_BITS-1:0]  msg [16];
	logic [3:0]            n_words;
	logic [2*KEY_BITS-1:0] msg_block;
	logic                  c_start;
	logic                  c_done;
	logic [KEY_BITS-1:0]   c_chain;
	logic [2*KEY_BITS-1:0] c_block;
	logic [KEY_BITS-1:0]   c_digest;

	sha256_compress compress_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (c_start),
		.chain_in (c_chain),
		.block_in (c_block),
		.done     (c_done),
		.digest   (c_digest)
	);

	// Message words, then 0x80 marker, then bit length
	// Length counts the 64-byte key block ahead of the message
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			if (i < n_words)
				msg_block[2*KEY_BITS-1-WORD_BITS*i -: WORD_BITS] = msg[i];
			else if (i == n_words)
				msg_block[2*KEY_BITS-1-WORD_BITS*i -: WORD_BITS] = 32'h8000_0000;
			else
				msg_block[2*KEY_BITS-1-WORD_BITS*i -: WORD_BITS] = '0;
		end
		msg_block[WORD_BITS-1:0] = 32'd512 + {n_words, 5'b0};
	end

	// Pick what the compressor works on next
	always_comb begin
		c_start = 1'b1;
		c_chain = SHA_H0;
		c_block = {key_reg, {KEY_BITS{1'b0}}} ^ {(KEY_BITS/4){8'h36}};
		if (start) begin
			c_start = 1'b1;
		end else if (finalize) begin
			// Digest still holds the ipad state here
			c_chain = c_digest;
			c_block = msg_block;
		end else if (c_done && phase == H_MSG) begin
			c_block = {key_reg, {KEY_BITS{1'b0}}} ^ {(KEY_BITS/4){8'h5c}};
		end else if (c_done && phase == H_OKEY) begin
			// Inner digest, pad, 768-bit length
			c_chain = c_digest;
			c_block = {inner, 32'h8000_0000, 192'b0, 32'd768};
		end else begin
			c_start = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase   <= H_IDLE;
			n_words <= '0;
		end else begin
			if (start) begin
				phase   <= H_IKEY;
				n_words <= '0;
			end else if (update) begin
				n_words <= n_words + 1'b1;
			end
			if (finalize)
				phase <= H_MSG;
			if (c_done) begin
				case (phase)
					H_IKEY:  phase <= H_COLLECT;
					H_MSG:   phase <= H_OKEY;
					H_OKEY:  phase <= H_OUTER;
					H_OUTER: phase <= H_IDLE;
					default: phase <= phase;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (key_update)
			key_reg <= key;
		if (update)
			msg[n_words] <= data_in;
		if (c_done && phase == H_MSG)
			inner <= c_digest;
	end

	assign ready      = c_done && phase == H_IKEY;
	assign hash_valid = c_done && phase == H_OUTER;
	// Held until the next block is done
	assign hash       = c_digest;

	// Message has to fit a single padded block
	assert property (@(posedge clk) disable iff (!rst_n) update |-> n_words < 13);
	assert property (@(posedge clk) disable iff (!rst_n) finalize |-> phase == H_COLLECT);

endmodule

// File: hdl/block_counter.sv
`timescale 1ns/10ps

module block_counter import prng_pkg::*; (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           inc,
	input  logic [$clog2(COUNT_WORDS)-1:0] word_sel,
	output logic [WORD_BITS-1:0]           word,
	output logic                           rekey_due
);

	// Generation counter, zero until the first key load
	logic [COUNT_BITS-1:0] count;

	// Bumped by key loads and by every finished hash
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			count <= '0;
		else if (inc)
			count <= count + 1'b1;
	end

	// Word 0 is the lowest 32 bits
	assign word = count[word_sel * WORD_BITS +: WORD_BITS];

	// Low bits all zero marks a rekey point
	assign rekey_due = (count[REKEY_LOG2-1:0] == '0);

endmodule

// File: hdl/prng_gen_fsm.sv
`timescale 1ns/10ps

module prng_gen_fsm import prng_pkg::*; (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           key_update,
	input  logic                           blk_req,
	input  logic                           hmac_ready,
	input  logic                           hash_valid,
	input  logic                           rekey_due,
	output logic                           gen_ready,
	output logic                           hmac_start,
	output logic                           hmac_update,
	output logic                           hmac_finalize,
	output logic [$clog2(COUNT_WORDS)-1:0] word_sel,
	output logic                           cnt_inc,
	output logic                           blk_load,
	output logic                           gen_rekey_en
);

	gen_state_t                     state;
	logic                           pending;
	logic [$clog2(COUNT_WORDS)-1:0] feed_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= IDLE;
			pending       <= 1'b0;
			feed_cnt      <= '0;
			gen_ready     <= 1'b0;
			hmac_start    <= 1'b0;
			hmac_update   <= 1'b0;
			hmac_finalize <= 1'b0;
			word_sel      <= '0;
			cnt_inc       <= 1'b0;
			blk_load      <= 1'b0;
			gen_rekey_en  <= 1'b0;
		end else begin
			hmac_start    <= 1'b0;
			hmac_update   <= 1'b0;
			hmac_finalize <= 1'b0;
			cnt_inc       <= 1'b0;
			blk_load      <= 1'b0;
			gen_rekey_en  <= 1'b0;

			// Nothing to hash until a key is in
			if (key_update)
				gen_ready <= 1'b1;
			if (blk_req)
				pending <= 1'b1;

			case (state)
				IDLE: begin
					if ((blk_req || pending) && gen_ready) begin
						pending    <= 1'b0;
						hmac_start <= 1'b1;
						feed_cnt   <= '0;
						state      <= INIT;
					end
				end
				// Key ipad block in progress
				INIT, REKEY_INIT: begin
					if (hmac_ready)
						state <= (state == INIT) ? INPUT : REKEY_INPUT;
				end
				// Stream counter words, word_sel lines up with each update
				INPUT, REKEY_INPUT: begin
					hmac_update <= 1'b1;
					word_sel    <= feed_cnt;
					feed_cnt    <= feed_cnt + 1'b1;
					if (feed_cnt == COUNT_WORDS - 1)
						state <= (state == INPUT) ? FINALIZE : REKEY_FINALIZE;
				end
				FINALIZE, REKEY_FINALIZE: begin
					hmac_finalize <= 1'b1;
					state         <= (state == FINALIZE) ? WAIT : REKEY_WAIT;
				end
				WAIT: begin
					if (hash_valid) begin
						cnt_inc <= 1'b1;
						// Rekey point, this hash never leaves the block
						if (rekey_due) begin
							hmac_start <= 1'b1;
							feed_cnt   <= '0;
							state      <= REKEY_INIT;
						end else begin
							blk_load <= 1'b1;
							state    <= IDLE;
						end
					end
				end
				REKEY_WAIT: begin
					if (hash_valid) begin
						cnt_inc      <= 1'b1;
						gen_rekey_en <= 1'b1;
						// Go on to the output block the reader waits for
						hmac_start   <= 1'b1;
						feed_cnt     <= '0;
						state        <= INIT;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Buffer asks again only once its last block was loaded
	assert property (@(posedge clk) disable iff (!rst_n) blk_req |-> !pending);
	// Engine only finishes while a hash is awaited
	assert property (@(posedge clk) disable iff (!rst_n)
		hash_valid |-> (state == WAIT || state == REKEY_WAIT));

endmodule

// File: hdl/output_word_buffer.sv
`timescale 1ns/10ps

module output_word_buffer import prng_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 gen_en,
	input  logic                 blk_load,
	input  logic [KEY_BITS-1:0]  hash,
	output logic                 blk_req,
	output logic                 rng_valid,
	output logic [WORD_BITS-1:0] rng_out
);

	logic [KEY_BITS-1:0] words;
	// Words left, 0 to 8
	logic [3:0]          held;
	logic                read_pending;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			held         <= '0;
			read_pending <= 1'b0;
			blk_req      <= 1'b0;
			rng_valid    <= 1'b0;
		end else begin
			blk_req   <= 1'b0;
			rng_valid <= 1'b0;
			if (gen_en || read_pending) begin
				if (held != 0) begin
					rng_valid    <= 1'b1;
					held         <= held - 1'b1;
					read_pending <= 1'b0;
				end else if (!read_pending) begin
					// Empty, ask for one block and hold the read
					blk_req      <= 1'b1;
					read_pending <= 1'b1;
				end
			end
			if (blk_load)
				held <= 4'(BLOCK_WORDS);
		end
	end

	always_ff @(posedge clk) begin
		if (blk_load)
			words <= hash;
		// Highest remaining word goes out first
		if ((gen_en || read_pending) && held != 0)
			rng_out <= words[(held - 1'b1) * WORD_BITS +: WORD_BITS];
	end

	// A new block only lands in an empty buffer
	assert property (@(posedge clk) disable iff (!rst_n) blk_load |-> held == 0);

endmodule

// File: hdl/output_prng.sv
`timescale 1ns/10ps

module output_prng import prng_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rng_key_update,
	input  logic [KEY_BITS-1:0]  rng_key,
	input  logic                 gen_en,
	output logic                 gen_ready,
	output logic                 rng_valid,
	output logic [WORD_BITS-1:0] rng_out,
	output logic                 gen_rekey_en,
	output logic [KEY_BITS-1:0]  gen_rekey_value
);

	logic                           blk_req;
	logic                           blk_load;
	logic                           hmac_start;
	logic                           hmac_ready;
	logic                           hmac_update;
	logic                           hmac_finalize;
	logic                           hash_valid;
	logic [KEY_BITS-1:0]            hash;
	logic [$clog2(COUNT_WORDS)-1:0] word_sel;
	logic [WORD_BITS-1:0]           ctr_word;
	logic                           rekey_due;
	logic                           cnt_inc;

	// Key loads count as a step of the counter too
	block_counter block_counter_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.inc       (rng_key_update | cnt_inc),
		.word_sel  (word_sel),
		.word      (ctr_word),
		.rekey_due (rekey_due)
	);

	prng_gen_fsm prng_gen_fsm_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.key_update    (rng_key_update),
		.blk_req       (blk_req),
		.hmac_ready    (hmac_ready),
		.hash_valid    (hash_valid),
		.rekey_due     (rekey_due),
		.gen_ready     (gen_ready),
		.hmac_start    (hmac_start),
		.hmac_update   (hmac_update),
		.hmac_finalize (hmac_finalize),
		.word_sel      (word_sel),
		.cnt_inc       (cnt_inc),
		.blk_load      (blk_load),
		.gen_rekey_en  (gen_rekey_en)
	);

	hmac_sha256 hmac_sha256_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.key_update (rng_key_update),
		.key        (rng_key),
		.start      (hmac_start),
		.update     (hmac_update),
		.data_in    (ctr_word),
		.finalize   (hmac_finalize),
		.ready      (hmac_ready),
		.hash_valid (hash_valid),
		.hash       (hash)
	);

	output_word_buffer output_word_buffer_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.gen_en    (gen_en),
		.blk_load  (blk_load),
		.hash      (hash),
		.blk_req   (blk_req),
		.rng_valid (rng_valid),
		.rng_out   (rng_out)
	);

	// Rekey value is valid while gen_rekey_en is high
	assign gen_rekey_value = hash;

endmodule

// File: bench/output_prng_tb.sv
`timescale 1ns/10ps

module output_prng_tb import prng_pkg::*; ();

	logic                 clk;
	logic                 rst_n;
	logic                 rng_key_update;
	logic [KEY_BITS-1:0]  rng_key;
	logic                 gen_en;
	logic                 gen_ready;
	logic                 rng_valid;
	logic [WORD_BITS-1:0] rng_out;
	logic                 gen_rekey_en;
	logic [KEY_BITS-1:0]  gen_rekey_value;

	// Generator key and the counters of the checked blocks, from the data file
	logic [KEY_BITS-1:0]   gen_key;
	logic [COUNT_BITS-1:0] ctr_list [8];
	int                    n_ctr = 0;
	bit                    data_ok = 1'b0;

	int errors = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int error_mark = 0;
	int valid_count = 0;
	int rekey_count = 0;
	logic [KEY_BITS-1:0] rekey_capture;
	int unsigned seed_value;

	// Generous bound, one block takes under 300 cycles
	int cycles = 0;
	int cycle_limit = 1100 * 300;

	output_prng output_prng_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.rng_key_update  (rng_key_update),
		.rng_key         (rng_key),
		.gen_en          (gen_en),
		.gen_ready       (gen_ready),
		.rng_valid       (rng_valid),
		.rng_out         (rng_out),
		.gen_rekey_en    (gen_rekey_en),
		.gen_rekey_value (gen_rekey_value)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run length guard
	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("run timed out after %0d cycles without finishing the tests", cycles);
			$display("tests failed");
			$finish;
		end
	end

	// Strobe monitors, sampled away from the active edge
	always @(negedge clk) begin
		if (rst_n && rng_valid)
			valid_count++;
		if (rst_n && gen_rekey_en) begin
			rekey_count++;
			rekey_capture = gen_rekey_value;
		end
	end

	function automatic logic [31:0] rot_right(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Reference SHA-256 compression, straight from the standard
	function automatic logic [255:0] sha_block(input logic [255:0] chain,
			input logic [511:0] blk);
		logic [31:0]  w [64];
		logic [31:0]  v [8];
		logic [31:0]  t1;
		logic [31:0]  t2;
		logic [31:0]  s0;
		logic [31:0]  s1;
		logic [255:0] result;
		for (int i = 0; i < 16; i++)
			w[i] = blk[511-32*i -: 32];
		// Full schedule up front
		for (int i = 16; i < 64; i++) begin
			s0 = rot_right(w[i-15], 7) ^ rot_right(w[i-15], 18) ^ (w[i-15] >> 3);
			s1 = rot_right(w[i-2], 17) ^ rot_right(w[i-2], 19) ^ (w[i-2] >> 10);
			w[i] = w[i-16] + s0 + w[i-7] + s1;
		end
		for (int i = 0; i < 8; i++)
			v[i] = chain[255-32*i -: 32];
		for (int i = 0; i < 64; i++) begin
			s1 = rot_right(v[4], 6) ^ rot_right(v[4], 11) ^ rot_right(v[4], 25);
			t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + SHA_K[i] + w[i];
			s0 = rot_right(v[0], 2) ^ rot_right(v[0], 13) ^ rot_right(v[0], 22);
			t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			// a..h shift down, e and a get the new values
			for (int j = 7; j > 0; j--)
				v[j] = v[j-1];
			v[4] = v[4] + t1;
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			result[255-32*i -: 32] = chain[255-32*i -: 32] + v[i];
		return result;
	endfunction

	// HMAC-SHA256, key up to 32 bytes, message of n whole words (n up to 7)
	function automatic logic [255:0] hmac_ref(input logic [255:0] key,
			input logic [223:0] msg, input int n);
		logic [511:0] kblk;
		logic [511:0] mblk;
		logic [255:0] state;
		logic [255:0] inner;
		kblk = {key, 256'b0};
		state = sha_block(SHA_H0, kblk ^ {64{8'h36}});
		mblk = '0;
		mblk[511 -: 224] = msg;
		mblk[511 - 32*n -: 32] = 32'h8000_0000;
		// Bit length includes the 64-byte ipad block
		mblk[63:0] = 512 + 32 * n;
		inner = sha_block(state, mblk);
		state = sha_block(SHA_H0, kblk ^ {64{8'h5c}});
		return sha_block(state, {inner, 32'h8000_0000, 160'b0, 64'd768});
	endfunction

	// Counter as four big-endian words, lowest word first
	function automatic logic [223:0] counter_msg(input logic [127:0] c);
		return {c[31:0], c[63:32], c[95:64], c[127:96], 96'b0};
	endfunction

	task automatic check_value(input logic [255:0] actual, input logic [255:0] expected,
			input string what);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != error_mark) begin
			tests_bad++;
			$display("test %s: FAIL, %0d mismatches", name, errors - error_mark);
		end else begin
			$display("test %s: ok", name);
		end
		error_mark = errors;
	endtask

	task automatic parse_testdata();
		int               fd;
		int               code;
		int               kats;
		int               kat_n;
		logic [7:0]       tag;
		logic [8*160-1:0] rest;
		logic [255:0]     kat_key;
		logic [223:0]     kat_msg;
		logic [255:0]     kat_exp;
		kats = 0;
		fd = $fopen("bench/output_prng_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/output_prng_testdata.txt");
			errors++;
		end else begin
			while ($fscanf(fd, " %c", tag) == 1) begin
				case (tag)
					"#": code = $fgets(rest, fd);
					"G": code = $fscanf(fd, "%h", gen_key);
					"A": code = $fscanf(fd, "%h", kat_key);
					"M": code = $fscanf(fd, "%d %h", kat_n, kat_msg);
					// Expected line closes one known-answer case
					"E": begin
						code = $fscanf(fd, "%h", kat_exp);
						check_value(hmac_ref(kat_key, kat_msg, kat_n), kat_exp,
							"reference HMAC against known answer");
						kats++;
					end
					"C": begin
						if (n_ctr < 8)
							code = $fscanf(fd, "%d", ctr_list[n_ctr]);
						n_ctr++;
					end
					default: begin
						$display("test data holds an unknown line tag '%c'", tag);
						errors++;
						code = $fgets(rest, fd);
					end
				endcase
			end
			$fclose(fd);
			check_value(kats, 2, "known-answer cases in test data");
			check_value(n_ctr, 5, "counter entries in test data");
			data_ok = (errors == 0);
		end
	endtask

	task automatic apply_key(input logic [KEY_BITS-1:0] key);
		rng_key = key;
		rng_key_update = 1'b1;
		@(posedge clk);
		#10;
		rng_key_update = 1'b0;
	endtask

	// One-cycle read strobe
	task automatic pulse_gen_en();
		gen_en = 1'b1;
		@(posedge clk);
		#10;
		gen_en = 1'b0;
	endtask

	// Waits for rng_valid, the cycle guard catches a hang
	task automatic take_word(output logic [WORD_BITS-1:0] w);
		while (!rng_valid) begin
			@(posedge clk);
			#10;
		end
		w = rng_out;
		@(posedge clk);
		#10;
	endtask

	task automatic fetch_word(output logic [WORD_BITS-1:0] w);
		pulse_gen_en();
		take_word(w);
	endtask

	// Reads words first..7 of one block and compares them with the model
	task automatic verify_block(input logic [KEY_BITS-1:0] key,
			input logic [COUNT_BITS-1:0] ctr, input int first, input bit gaps);
		logic [KEY_BITS-1:0]  expected;
		logic [WORD_BITS-1:0] w;
		int                   gap;
		expected = hmac_ref(key, counter_msg(ctr), COUNT_WORDS);
		for (int i = first; i < BLOCK_WORDS; i++) begin
			if (gaps) begin
				gap = $urandom % 4;
				repeat (gap) begin
					@(posedge clk);
					#10;
				end
			end
			fetch_word(w);
			check_value(w, expected[KEY_BITS-1-WORD_BITS*i -: WORD_BITS],
				$sformatf("word %0d of block %0d", i, ctr));
		end
	endtask

	task automatic skip_block();
		logic [WORD_BITS-1:0] w;
		for (int i = 0; i < BLOCK_WORDS; i++)
			fetch_word(w);
	endtask

	task automatic run_tests();
		logic [KEY_BITS-1:0]  expected;
		logic [KEY_BITS-1:0]  new_key;
		logic [WORD_BITS-1:0] w;
		int                   before_rekey;
		repeat (5) @(posedge clk);
		#10;
		rst_n = 1'b1;

		// Quiet outputs out of reset
		repeat (3) begin
			@(posedge clk);
			#10;
			check_value(gen_ready, 1'b0, "gen_ready after reset");
			check_value(rng_valid, 1'b0, "rng_valid after reset");
			check_value(gen_rekey_en, 1'b0, "gen_rekey_en after reset");
		end
		// Read with no key yet, must stay unanswered
		pulse_gen_en();
		repeat (20) begin
			@(posedge clk);
			#10;
		end
		check_value(valid_count, 0, "words before the first key load");
		apply_key(gen_key);
		check_value(gen_ready, 1'b1, "gen_ready after key load");
		expected = hmac_ref(gen_key, counter_msg(ctr_list[0]), COUNT_WORDS);
		take_word(w);
		check_value(w, expected[255:224], "first word of block 1");
		check_value(valid_count, 1, "rng_valid pulses for the first read");
		finish_test("reset");

		verify_block(gen_key, ctr_list[0], 1, 1'b0);
		check_value(valid_count, BLOCK_WORDS, "rng_valid pulses over block 1");
		finish_test("word order");

		verify_block(gen_key, ctr_list[1], 0, 1'b1);
		check_value(valid_count, 2 * BLOCK_WORDS, "rng_valid pulses over block 2");
		finish_test("counter advance");

		// Drain up to the block just before the discarded one
		for (int b = ctr_list[1] + 1; b < ctr_list[2] - 1; b++)
			skip_block();
		before_rekey = BLOCK_WORDS * (ctr_list[2] - 2);
		check_value(valid_count, before_rekey, "words before the rekey point");
		check_value(rekey_count, 0, "rekey strobes before the rekey point");
		// Pending read spans the discarded hash and the rekey hash
		expected = hmac_ref(gen_key, counter_msg(ctr_list[3]), COUNT_WORDS);
		new_key = hmac_ref(gen_key, counter_msg(ctr_list[2]), COUNT_WORDS);
		fetch_word(w);
		check_value(w, expected[255:224], "first word after the rekey");
		check_value(valid_count, before_rekey + 1, "one word for the pending read");
		check_value(rekey_count, 1, "gen_rekey_en pulses");
		check_value(rekey_capture, new_key, "gen_rekey_value");
		finish_test("rekey");

		// New key from the rekey strobe, old key still behind the held words
		apply_key(rekey_capture);
		verify_block(gen_key, ctr_list[3], 1, 1'b0);
		verify_block(new_key, ctr_list[4], 0, 1'b1);
		check_value(valid_count, before_rekey + 2 * BLOCK_WORDS, "words after key reload");
		check_value(rekey_count, 1, "gen_rekey_en pulses after key reload");
		finish_test("key reload");
	endtask

	initial begin
		rst_n = 1'b0;
		rng_key_update = 1'b0;
		rng_key = '0;
		gen_en = 1'b0;
		seed_value = $urandom(25532);
		parse_testdata();
		finish_test("test data and reference model");
		if (data_ok)
			run_tests();
		$display("tests run %0d, passing %0d, failing %0d, mismatches %0d",
			tests_run, tests_run - tests_bad, tests_bad, errors);
		if (errors == 0 && tests_bad == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: bench/output_prng_testdata.txt
# Tags: A key, M word count and message words, E expected HMAC for the reference model
# G generator key; C decimal counters: block 1, block 2, rekey, after rekey, after reload
# RFC 4231 case 1, 20-byte key padded with zeros
A 0b0b0b0b0b0b0b0b0b0b0b0b0b0b0b0b0b0b0b0b000000000000000000000000
M 2 48692054686572650000000000000000000000000000000000000000
E b0344c61d8db38535ca8afceaf0bf12b881dc200c9833da726e9376c2e32cff7
# RFC 4231 case 2, key Jefe
A 4a65666500000000000000000000000000000000000000000000000000000000
M 7 7768617420646f2079612077616e7420666f72206e6f7468696e673f
E 5bdcc146bf60754e6a042426089575c75a003f089d2739839dec58b964ec3843
# Generator key loaded after reset
G 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f
# First two output blocks
C 1
C 2
# Hash offered on gen_rekey_en
C 1025
# Output block after the rekey, still under the old key
C 1026
# First block under the reloaded key
C 1028

// File: sim.f
hdl/prng_pkg.sv
hdl/sha256_compress.sv
hdl/hmac_sha256.sv
hdl/block_counter.sv
hdl/prng_gen_fsm.sv
hdl/output_word_buffer.sv
hdl/output_prng.sv
bench/output_prng_tb.sv

// File: Bender.yml
package:
  name: output_prng

sources:
  - files:
      - hdl/prng_pkg.sv
      - hdl/sha256_compress.sv
      - hdl/hmac_sha256.sv
      - hdl/block_counter.sv
      - hdl/prng_gen_fsm.sv
      - hdl/output_word_buffer.sv
      - hdl/output_prng.sv
  - target: test
    files:
      - bench/output_prng_tb.sv
